//--- verilog/board_pkg.sv
package board_pkg;

    // ==============================
    // Board I/O widths
    // ==============================

    localparam int KEY_W  = 4;   // Push keys on the trainer board
    localparam int SW_W   = 8;   // Slide switches
    localparam int LED_W  = 12;  // Discrete LEDs, also the shift register width
    localparam int DIGITS = 8;   // Seven-segment digits

    // ==============================
    // Divider widths
    // ==============================

    // The debounce counter saturates after 2**DEBOUNCE_W stable cycles
    localparam int DEBOUNCE_W  = 3;
    localparam int SHIFT_DIV_W = 6;  // Shift strobe once every 64 cycles
    localparam int SEG_DIV_W   = 2;  // Display scan strobe once every 4 cycles

    // ==============================
    // Display output
    // ==============================

    typedef struct packed {
        logic [6:0]        segments;  // Segments a to g, a on the top bit, active low
        logic              dot;       // Decimal point, active low
        logic [DIGITS-1:0] digit;     // One-hot digit select, active low
    } seg_out_t;

endpackage

//--- verilog/seq_pkg.sv
package seq_pkg;

    // States shared by both detectors, HIT is reached only by the Moore machine
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        GOT1  = 2'd1,
        GOT10 = 2'd2,
        HIT   = 2'd3
    } det_state_t;

    // Oldest bit of the pattern sits on the left
    localparam logic [2:0] PATTERN = 3'b101;

    // ==============================
    // Event counters
    // ==============================

    // The 32-bit view of this struct is the number sent to the display
    typedef struct packed {
        logic [15:0] strobe_cnt;  // Upper four digits
        logic [7:0]  moore_cnt;   // Middle two digits
        logic [7:0]  mealy_cnt;   // Lower two digits
    } event_counts_t;

endpackage

//--- verilog/sync_debounce.sv
`timescale 1ns/100ps

module sync_debounce import board_pkg::*; #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     i_arst_n,
    input  payload_t i_raw,
    output payload_t o_clean
);

    payload_t              sync_q1;  // First synchronizer stage, may go metastable
    payload_t              sync_q2;  // Safe to use in the clock domain
    payload_t              cand_q;   // Value waiting to prove it is stable
    logic [DEBOUNCE_W-1:0] stable_q; // Cycles the candidate has held

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= i_raw;
            sync_q2 <= sync_q1;
        end
    end

    // Any difference restarts the wait, so short glitches never get through
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cand_q   <= '0;
            stable_q <= '0;
            o_clean  <= '0;
        end else if (sync_q2 != cand_q) begin
            cand_q   <= sync_q2;     // New candidate value
            stable_q <= '0;
        end else if (stable_q != '1) begin
            stable_q <= stable_q + 1'b1;
        end else begin
            o_clean  <= cand_q;      // Held long enough to accept
        end
    end

endmodule

//--- verilog/strobe_gen.sv
`timescale 1ns/100ps

module strobe_gen #(
    parameter int W = 4
) (
    input  logic clk,
    input  logic i_arst_n,
    output logic o_strobe
);

    logic [W-1:0] cnt_q;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cnt_q    <= '0;
            o_strobe <= 1'b0;
        end else begin
            cnt_q    <= cnt_q + 1'b1;
            o_strobe <= (cnt_q == '1);  // High while the counter sits at zero after the wrap
        end
    end

    // A strobe is a single-cycle event, one per full count period
    a_strobe_single_cycle : assert property (
        @(posedge clk) disable iff (!i_arst_n) o_strobe |=> !o_strobe
    );

endmodule

//--- verilog/moore_detector.sv
`timescale 1ns/100ps

module moore_detector import seq_pkg::*; (
    input  logic clk,
    input  logic i_arst_n,
    input  logic i_en,
    input  logic i_bit,
    output logic o_hit
);

    det_state_t state_q;
    det_state_t state_d;

    always_comb begin
        state_d = state_q;
        if (i_en) begin
            unique case (state_q)
                IDLE:  state_d = (i_bit == PATTERN[2]) ? GOT1  : IDLE;
                GOT1:  state_d = (i_bit == PATTERN[1]) ? GOT10 : GOT1;
                GOT10: state_d = (i_bit == PATTERN[0]) ? HIT   : IDLE;
                // The last 1 of a match may start the next one
                HIT:   state_d = (i_bit == PATTERN[1]) ? GOT10 : GOT1;
                default: state_d = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign o_hit = (state_q == HIT);  // Output follows the state only

    a_state_legal : assert property (
        @(posedge clk) disable iff (!i_arst_n)
        !$isunknown(state_q) && (state_q inside {IDLE, GOT1, GOT10, HIT})
    );

endmodule

//--- verilog/mealy_detector.sv
`timescale 1ns/100ps

module mealy_detector import seq_pkg::*; (
    input  logic clk,
    input  logic i_arst_n,
    input  logic i_en,
    input  logic i_bit,
    output logic o_hit
);

    det_state_t state_q;
    det_state_t state_d;

    always_comb begin
        state_d = state_q;
        if (i_en) begin
            case (state_q)
                IDLE:  state_d = (i_bit == PATTERN[2]) ? GOT1  : IDLE;
                GOT1:  state_d = (i_bit == PATTERN[1]) ? GOT10 : GOT1;
                GOT10: state_d = (i_bit == PATTERN[0]) ? GOT1  : IDLE;  // Hit, overlap kept
                default: state_d = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Fires in the same cycle as the completing bit
    assign o_hit = i_en && (state_q == GOT10) && (i_bit == PATTERN[0]);

    a_hit_needs_enable : assert property (
        @(posedge clk) disable iff (!i_arst_n) o_hit |-> i_en
    );

endmodule

//--- verilog/seq_monitor.sv
`timescale 1ns/100ps

module seq_monitor import board_pkg::*, seq_pkg::*; (
    input  logic             clk,
    input  logic             i_arst_n,
    input  logic             i_shift_stb,
    input  logic             i_bit,
    output logic [LED_W-1:0] o_shift_reg,
    output event_counts_t    o_counts
);

    logic [LED_W-1:0] shift_q;
    logic             shift_dly;   // Detector enable, one cycle after the shift
    logic             moore_hit;
    logic             mealy_hit;
    event_counts_t    counts_q;

    // ==============================
    // Shift register
    // ==============================

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            shift_q   <= '0;
            shift_dly <= 1'b0;
        end else begin
            shift_dly <= i_shift_stb;
            if (i_shift_stb) begin
                shift_q <= {shift_q[LED_W-2:0], i_bit};  // Newest bit enters at bit 0
            end
        end
    end

    // ==============================
    // Pattern detectors
    // ==============================

    moore_detector moore_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_en     (shift_dly),
        .i_bit    (shift_q[0]),
        .o_hit    (moore_hit)
    );

    mealy_detector mealy_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_en     (shift_dly),
        .i_bit    (shift_q[0]),
        .o_hit    (mealy_hit)
    );

    // All three counters wrap silently
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            counts_q <= '0;
        end else begin
            if (i_shift_stb) begin
                counts_q.strobe_cnt <= counts_q.strobe_cnt + 1'b1;
            end
            // Moore hit is seen one enable after the bit that completed it
            if (shift_dly && moore_hit) begin
                counts_q.moore_cnt <= counts_q.moore_cnt + 1'b1;
            end
            if (shift_dly && mealy_hit) begin
                counts_q.mealy_cnt <= counts_q.mealy_cnt + 1'b1;
            end
        end
    end

    assign o_shift_reg = shift_q;
    assign o_counts    = counts_q;

endmodule

//--- verilog/seven_segment.sv
`timescale 1ns/100ps

module seven_segment import board_pkg::*; (
    input  logic                clk,
    input  logic                i_arst_n,
    input  logic                i_scan_stb,
    input  logic [4*DIGITS-1:0] i_number,
    input  logic [DIGITS-1:0]   i_dots,
    output seg_out_t            o_seg
);

    localparam int IDX_W = $clog2(DIGITS);

    logic [IDX_W-1:0] digit_idx_q;
    logic [3:0]       nibble;

    // Active high abcdefg pattern, a on bit 6
    function automatic logic [6:0] hex_to_seg(input logic [3:0] hex);
        logic [6:0] seg;
        case (hex)
            4'h0: seg = 7'b1111110;
            4'h1: seg = 7'b0110000;
            4'h2: seg = 7'b1101101;
            4'h3: seg = 7'b1111001;
            4'h4: seg = 7'b0110011;
            4'h5: seg = 7'b1011011;
            4'h6: seg = 7'b1011111;
            4'h7: seg = 7'b1110000;
            4'h8: seg = 7'b1111111;
            4'h9: seg = 7'b1111011;
            4'hA: seg = 7'b1110111;
            4'hB: seg = 7'b0011111;
            4'hC: seg = 7'b1001110;
            4'hD: seg = 7'b0111101;
            4'hE: seg = 7'b1001111;
            default: seg = 7'b1000111;  // F
        endcase
        return seg;
    endfunction

    // ==============================
    // Digit scan
    // ==============================

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            digit_idx_q <= '0;
        end else if (i_scan_stb) begin
            digit_idx_q <= digit_idx_q + 1'b1;  // Wraps from 7 back to 0
        end
    end

    assign nibble = i_number[digit_idx_q*4 +: 4];

    // Segment pattern and digit select change on the same edge
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_seg.segments <= ~hex_to_seg(4'h0);
            o_seg.dot      <= 1'b1;
            o_seg.digit    <= ~DIGITS'(1);
        end else begin
            o_seg.segments <= ~hex_to_seg(nibble);
            o_seg.dot      <= ~i_dots[digit_idx_q];
            o_seg.digit    <= ~(DIGITS'(1) << digit_idx_q);
        end
    end

    a_one_digit_on : assert property (
        @(posedge clk) disable iff (!i_arst_n) $onehot(~o_seg.digit)
    );

endmodule

//--- verilog/board_top.sv
`timescale 1ns/100ps

module board_top import board_pkg::*, seq_pkg::*; (
    input  logic              clk,
    input  logic              i_arst_n,
    input  logic [KEY_W-1:0]  i_key,
    input  logic [SW_W-1:0]   i_sw,
    output logic [LED_W-1:0]  o_led,
    output logic [7:0]        o_abcdefgh,
    output logic [DIGITS-1:0] o_digit
);

    logic [KEY_W-1:0] key_db;
    logic [SW_W-1:0]  sw_db;
    logic             shift_stb;
    logic             scan_stb;
    logic [LED_W-1:0] shift_reg;
    event_counts_t    counts;
    seg_out_t         seg;

    // ==============================
    // Input conditioning
    // ==============================

    // Keys and switches pull low when active
    sync_debounce #(.payload_t(logic [KEY_W-1:0])) key_debounce_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_raw    (~i_key),
        .o_clean  (key_db)
    );

    sync_debounce #(.payload_t(logic [SW_W-1:0])) sw_debounce_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_raw    (~i_sw),
        .o_clean  (sw_db)
    );

    // ==============================
    // Strobes and sequence logic
    // ==============================

    strobe_gen #(.W(SHIFT_DIV_W)) shift_strobe_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .o_strobe (shift_stb)
    );

    strobe_gen #(.W(SEG_DIV_W)) scan_strobe_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .o_strobe (scan_stb)
    );

    seq_monitor monitor_i (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_shift_stb (shift_stb),
        .i_bit       (key_db[1]),  // Key 1 feeds the shift register
        .o_shift_reg (shift_reg),
        .o_counts    (counts)
    );

    assign o_led = ~shift_reg;  // LEDs are lit by a low level

    seven_segment display_i (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_scan_stb (scan_stb),
        .i_number   (counts),
        .i_dots     (sw_db),
        .o_seg      (seg)
    );

    assign o_abcdefgh = {seg.segments, seg.dot};
    assign o_digit    = seg.digit;

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter int RESET_CYCLES = 4
) (
    output logic o_clk,
    output logic o_arst_n
);

    initial begin
        o_clk    = 1'b0;
        o_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_arst_n = 1'b1;  // Released between rising edges
    end

    always #5 o_clk = ~o_clk;  // 10 ns period

endmodule

//--- bench/tb_board_top.sv
`timescale 1ns/100ps

module tb_board_top import board_pkg::*, seq_pkg::*; ();

    localparam int          N_BITS    = 48;
    localparam int          PERIOD    = 2 ** SHIFT_DIV_W;  // Cycles per shift strobe
    localparam int          SCAN      = 2 ** SEG_DIV_W;    // Cycles per display digit
    localparam int          FINAL_CYC = PERIOD * N_BITS + 4;
    localparam logic [31:0] SEED      = 32'h8cf360e5;

    logic              clk;
    logic              i_arst_n;
    logic [KEY_W-1:0]  i_key = '1;       // All keys released
    logic [SW_W-1:0]   i_sw = '1;        // All switches off
    logic [LED_W-1:0]  o_led;
    logic [7:0]        o_abcdefgh;
    logic [DIGITS-1:0] o_digit;

    int                cyc;              // Rising edges since reset release
    int                bits_sent = 0;
    logic              cur_bit = 1'b0;   // Key 1 level before the pin inversion
    logic [KEY_W-1:0]  glitch_mask = '0;
    logic [SW_W-1:0]   sw_set = '0;      // Switches that should read as set
    logic [LED_W-1:0]  model_reg;
    int                model_hits;
    logic              last_hit;
    int                model_strobes;
    event_counts_t     exp_counts;
    logic              final_chk;

    tb_clock clock_i (.o_clk(clk), .o_arst_n(i_arst_n));

    board_top dut_i (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_key      (i_key),
        .i_sw       (i_sw),
        .o_led      (o_led),
        .o_abcdefgh (o_abcdefgh),
        .o_digit    (o_digit)
    );

    // Common anode hex patterns, a on the top bit
    function automatic logic [6:0] seg_pattern(input logic [3:0] hex);
        case (hex)
            4'h0: return 7'b0000001;
            4'h1: return 7'b1001111;
            4'h2: return 7'b0010010;
            4'h3: return 7'b0000110;
            4'h4: return 7'b1001100;
            4'h5: return 7'b0100100;
            4'h6: return 7'b0100000;
            4'h7: return 7'b0001111;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0000100;
            4'hA: return 7'b0001000;
            4'hB: return 7'b1100000;
            4'hC: return 7'b0110001;
            4'hD: return 7'b1000010;
            4'hE: return 7'b0110000;
            default: return 7'b0111000;
        endcase
    endfunction

    // Digit shown after rising edge k, the scan index steps on edges 5, 9, 13 and so on
    function automatic int digit_at(input int k);
        return (k < 2) ? 0 : ((k - 2) / SCAN) % DIGITS;
    endfunction

    function automatic logic [3:0] nibble_of(input event_counts_t c, input int d);
        logic [31:0] num;
        num = c;
        return num[d*4 +: 4];
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // ==============================
    // Reference model
    // ==============================

    always @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cyc           <= 0;
            model_reg     <= '0;
            model_hits    <= 0;
            last_hit      <= 1'b0;
            model_strobes <= 0;
        end else begin
            cyc <= cyc + 1;
            if (cyc > 0 && cyc % PERIOD == 0) begin  // Edge 64p+1 takes the strobe
                model_reg     <= {model_reg[LED_W-2:0], cur_bit};
                model_strobes <= model_strobes + 1;
                last_hit      <= ({model_reg[1:0], cur_bit} == PATTERN);
                if ({model_reg[1:0], cur_bit} == PATTERN) begin
                    model_hits <= model_hits + 1;  // Overlap comes free from the window
                end
            end
        end
    end

    // Moore lags by one enable, so a final completion is still pending there
    always_comb begin
        exp_counts.strobe_cnt = 16'(model_strobes);
        exp_counts.moore_cnt  = 8'(model_hits - int'(last_hit));
        exp_counts.mealy_cnt  = 8'(model_hits);
    end

    // ==============================
    // Stimulus
    // ==============================

    always @(posedge clk) begin
        int              phase;
        logic            new_bit;
        logic [SW_W-1:0] sw_val;
        phase = (cyc + 1) % PERIOD;
        if (i_arst_n && bits_sent < N_BITS) begin
            if (phase == PERIOD / 2) begin
                new_bit   = 1'($urandom_range(0, 1));
                cur_bit   <= new_bit;
                i_key     <= {2'b11, ~new_bit, 1'b1};  // Pressed key pulls its pin low
                bits_sent <= bits_sent + 1;
            end
            if (phase == PERIOD - 4) begin
                case ($urandom_range(0, 3))
                    0: glitch_mask <= 4'b0000;
                    1: glitch_mask <= 4'b0010;
                    2: glitch_mask <= 4'b1000;
                    default: glitch_mask <= 4'b0011;
                endcase
            end
            if (phase == PERIOD - 3) begin
                i_key <= i_key ^ glitch_mask;  // Short pulse just before the strobe
            end
            if (phase == 0) begin
                i_key  <= i_key ^ glitch_mask;  // Ends the 3-cycle pulse
                sw_val = SW_W'($urandom);
                i_sw   <= sw_val;
                sw_set <= ~sw_val;
            end
        end
    end

    // ==============================
    // Checks
    // ==============================

    a_led_model : assert property (@(posedge clk) disable iff (!i_arst_n)
        o_led == ~model_reg)
        else abort_run($sformatf("FAILED at %0t ns: LEDs differ from the model register", $time));

    a_zero_at_start : assert property (@(posedge clk) disable iff (!i_arst_n)
        (cyc <= PERIOD + 1) |-> (o_abcdefgh[7:1] == seg_pattern(4'h0)))
        else abort_run($sformatf("FAILED at %0t ns: digit not 0 before first count", $time));

    a_single_digit : assert property (@(posedge clk) disable iff (!i_arst_n)
        $onehot(~o_digit))
        else abort_run($sformatf("FAILED at %0t ns: digit select is not one-hot", $time));

    a_scan_order : assert property (@(posedge clk) disable iff (!i_arst_n)
        o_digit == ~(DIGITS'(1) << digit_at(cyc)))
        else abort_run($sformatf("FAILED at %0t ns: wrong digit selected", $time));

    // Debounced switches settle 11 edges after a change
    a_dot_switch : assert property (@(posedge clk) disable iff (!i_arst_n)
        (cyc % PERIOD >= 12) |-> (o_abcdefgh[0] == !(|(sw_set & ~o_digit))))
        else abort_run($sformatf("FAILED at %0t ns: decimal point differs from switch", $time));

    a_final_counts : assert property (@(posedge clk) disable iff (!i_arst_n)
        final_chk |-> (o_abcdefgh[7:1] == seg_pattern(nibble_of(exp_counts, digit_at(cyc)))))
        else abort_run($sformatf("FAILED at %0t ns: shown count differs from model", $time));

    initial begin
        int                waited;
        logic [DIGITS-1:0] seen;
        logic [DIGITS-1:0] pending;
        void'($urandom(SEED));
        final_chk = 1'b0;
        waited    = 0;
        while (i_arst_n !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > 20) abort_run("Timeout: reset was never released");
        end
        waited = 0;
        while (cyc < FINAL_CYC) begin
            @(negedge clk);
            waited++;
            if (waited > FINAL_CYC + 100) abort_run("Timeout: the bit stream never finished");
        end
        // Counts are settled here and the next strobe is about 60 cycles away
        final_chk = 1'b1;
        seen      = '0;
        pending   = '0;
        waited    = 0;
        while (seen != '1) begin
            @(negedge clk);
            seen    = seen | pending;  // Digit of the last cycle has now been checked
            pending = ~o_digit;
            waited++;
            if (waited > 2 * SCAN * DIGITS) abort_run("Timeout: display did not scan all digits");
        end
        final_chk = 1'b0;
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- board_lab.f
verilog/board_pkg.sv
verilog/seq_pkg.sv
verilog/sync_debounce.sv
verilog/strobe_gen.sv
verilog/moore_detector.sv
verilog/mealy_detector.sv
verilog/seq_monitor.sv
verilog/seven_segment.sv
verilog/board_top.sv
bench/tb_clock.sv
bench/tb_board_top.sv

//--- Makefile
# Verilator flow for board_lab, every variable can be set on the command line

VERILATOR ?= verilator
TOP       ?= tb_board_top
FILELIST  ?= board_lab.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST PASS

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the pass line shows up in the output
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
